// ==== hdl/mmu_geom_pkg.sv ====
package mmu_geom_pkg;

    localparam int VA_W   = 32;
    localparam int VPPN_W = 19;             // va[31:13]
    localparam int PPN_W  = 20;
    localparam int ASID_W = 10;
    localparam int PS_W   = 6;              // width of the page size field

    localparam int TLB_N  = 16;
    localparam int IDX_W  = 4;

    localparam int PS_4K  = 12;
    localparam int PS_4M  = 21;

    localparam int XLAT_DEPTH  = 4;         // queue entries, also requester credits
    localparam int RSP_CREDITS = 2;
    localparam int PTR_W       = $clog2(XLAT_DEPTH);
    localparam int CNT_W       = $clog2(XLAT_DEPTH + 1);

    typedef logic [VPPN_W-1:0] vppn_t;
    typedef logic [PPN_W-1:0]  ppn_t;
    typedef logic [ASID_W-1:0] asid_t;

    // response word, read as pa or as fault record depending on rsp_fault
    typedef union packed {
        logic [VA_W-1:0] pa;
        struct packed {
            logic [5:0]  ecode;
            logic [8:0]  esubcode;
            logic [16:0] rsvd;              // always zero
        } fault;
    } xlat_word_u;

endpackage

// ==== hdl/mmu_csr_pkg.sv ====
package mmu_csr_pkg;

    // one selector value per register, plus the tlbwr command
    typedef enum logic [3:0] {
        SEL_CRMD,
        SEL_DMW0,
        SEL_DMW1,
        SEL_ASID,
        SEL_TLBEHI,
        SEL_TLBELO0,
        SEL_TLBELO1,
        SEL_TLBIDX,
        SEL_TLBWR                           // data ignored
    } cfg_sel_e;

    localparam int CRMD_PLV_LSB    = 0;     // 2 bits
    localparam int CRMD_DA         = 3;
    localparam int CRMD_PG         = 4;

    localparam int DMW_PLV0        = 0;
    localparam int DMW_PLV3        = 3;
    localparam int DMW_PSEG_LSB    = 25;    // 3 bits
    localparam int DMW_VSEG_LSB    = 29;    // 3 bits

    localparam int ASID_LSB        = 0;
    localparam int TLBEHI_VPPN_LSB = 13;

    localparam int ELO_V           = 0;
    localparam int ELO_D           = 1;
    localparam int ELO_PLV_LSB     = 2;     // 2 bits
    localparam int ELO_MAT_LSB     = 4;     // 2 bits
    localparam int ELO_G           = 6;
    localparam int ELO_PPN_LSB     = 8;

    localparam int TLBIDX_IDX_LSB  = 0;
    localparam int TLBIDX_PS_LSB   = 24;
    localparam int TLBIDX_NE       = 31;

    typedef enum logic [1:0] {
        ACC_FETCH,
        ACC_LOAD,
        ACC_STORE
    } acc_e;

    localparam logic [5:0] EC_PIL  = 6'h01;
    localparam logic [5:0] EC_PIS  = 6'h02;
    localparam logic [5:0] EC_PIF  = 6'h03;
    localparam logic [5:0] EC_PME  = 6'h04;
    localparam logic [5:0] EC_PPI  = 6'h07;
    localparam logic [5:0] EC_TLBR = 6'h3f;

endpackage

// ==== hdl/mmu_csr_regs.sv ====
module mmu_csr_regs (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              cfg_we,
    input  mmu_csr_pkg::cfg_sel_e             cfg_sel,
    input  logic [31:0]                       cfg_wdata,
    output logic [31:0]                       crmd,
    output logic [31:0]                       dmw0,
    output logic [31:0]                       dmw1,
    output mmu_geom_pkg::asid_t               asid,
    output logic                              tlb_we,
    output logic [mmu_geom_pkg::IDX_W-1:0]    tlb_idx,
    output logic                              w_e,
    output logic [mmu_geom_pkg::PS_W-1:0]     w_ps,
    output mmu_geom_pkg::vppn_t               w_vppn,
    output mmu_geom_pkg::asid_t               w_asid,
    output logic                              w_g,
    output logic [31:0]                       w_lo0,
    output logic [31:0]                       w_lo1
);
    import mmu_geom_pkg::*;
    import mmu_csr_pkg::*;

    logic ne;                               // tlbidx.ne, entry not present

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            crmd    <= '0;
            dmw0    <= '0;
            dmw1    <= '0;
            asid    <= '0;
            w_vppn  <= '0;
            w_lo0   <= '0;
            w_lo1   <= '0;
            tlb_idx <= '0;
            w_ps    <= '0;
            ne      <= 1'b0;
        end else if (cfg_we) begin
            case (cfg_sel)
                SEL_CRMD:    crmd   <= cfg_wdata;
                SEL_DMW0:    dmw0   <= cfg_wdata;
                SEL_DMW1:    dmw1   <= cfg_wdata;
                SEL_ASID:    asid   <= cfg_wdata[ASID_LSB +: ASID_W];
                SEL_TLBEHI:  w_vppn <= cfg_wdata[TLBEHI_VPPN_LSB +: VPPN_W];
                SEL_TLBELO0: w_lo0  <= cfg_wdata;
                SEL_TLBELO1: w_lo1  <= cfg_wdata;
                SEL_TLBIDX: begin
                    tlb_idx <= cfg_wdata[TLBIDX_IDX_LSB +: IDX_W];
                    w_ps    <= cfg_wdata[TLBIDX_PS_LSB +: PS_W];
                    ne      <= cfg_wdata[TLBIDX_NE];
                end
                default: ;                  // tlbwr handled below
            endcase
        end
    end

    // tlbwr writes the staged entry at this same edge
    assign tlb_we = cfg_we && (cfg_sel == SEL_TLBWR);

    assign w_e    = ~ne;
    assign w_asid = asid;
    assign w_g    = w_lo0[ELO_G] & w_lo1[ELO_G];   // global only if both halves say so

endmodule

// ==== hdl/tlb_array.sv ====
module tlb_array (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              tlb_we,
    input  logic [mmu_geom_pkg::IDX_W-1:0]    tlb_idx,
    input  logic                              w_e,
    input  logic [mmu_geom_pkg::PS_W-1:0]     w_ps,
    input  mmu_geom_pkg::vppn_t               w_vppn,
    input  mmu_geom_pkg::asid_t               w_asid,
    input  logic                              w_g,
    input  logic [31:0]                       w_lo0,
    input  logic [31:0]                       w_lo1,
    input  logic [mmu_geom_pkg::VA_W-1:0]     s_va,
    input  mmu_geom_pkg::asid_t               s_asid,
    output logic                              s_found,
    output mmu_geom_pkg::ppn_t                s_ppn,
    output logic [mmu_geom_pkg::PS_W-1:0]     s_ps,
    output logic [1:0]                        s_plv,
    output logic [1:0]                        s_mat,
    output logic                              s_d,
    output logic                              s_v
);
    import mmu_geom_pkg::*;
    import mmu_csr_pkg::*;

    logic [TLB_N-1:0]   e_q;
    logic [TLB_N-1:0]   g_q;
    logic [PS_W-1:0]    ps_q [TLB_N];
    vppn_t              vppn_q [TLB_N];
    asid_t              asid_q [TLB_N];

    // page halves, index is {entry, odd}
    ppn_t               ppn_q [2*TLB_N];
    logic [1:0]         plv_q [2*TLB_N];
    logic [1:0]         mat_q [2*TLB_N];
    logic [2*TLB_N-1:0] d_q;
    logic [2*TLB_N-1:0] v_q;

    logic [TLB_N-1:0]   hit;
    logic [IDX_W-1:0]   hit_idx;
    logic               odd;
    logic [IDX_W:0]     half_sel;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= '0;                      // all entries invalid
        end else if (tlb_we) begin
            e_q[tlb_idx] <= w_e;
        end
    end

    always_ff @(posedge aclk) begin
        if (tlb_we) begin
            g_q[tlb_idx]    <= w_g;
            ps_q[tlb_idx]   <= w_ps;
            vppn_q[tlb_idx] <= w_vppn;
            asid_q[tlb_idx] <= w_asid;

            ppn_q[{tlb_idx, 1'b0}] <= w_lo0[ELO_PPN_LSB +: PPN_W];
            plv_q[{tlb_idx, 1'b0}] <= w_lo0[ELO_PLV_LSB +: 2];
            mat_q[{tlb_idx, 1'b0}] <= w_lo0[ELO_MAT_LSB +: 2];
            d_q[{tlb_idx, 1'b0}]   <= w_lo0[ELO_D];
            v_q[{tlb_idx, 1'b0}]   <= w_lo0[ELO_V];

            ppn_q[{tlb_idx, 1'b1}] <= w_lo1[ELO_PPN_LSB +: PPN_W];
            plv_q[{tlb_idx, 1'b1}] <= w_lo1[ELO_PLV_LSB +: 2];
            mat_q[{tlb_idx, 1'b1}] <= w_lo1[ELO_MAT_LSB +: 2];
            d_q[{tlb_idx, 1'b1}]   <= w_lo1[ELO_D];
            v_q[{tlb_idx, 1'b1}]   <= w_lo1[ELO_V];
        end
    end

    // parallel compare, 4M pages ignore the low 9 vppn bits
    always_comb begin
        for (int i = 0; i < TLB_N; i++) begin
            hit[i] = e_q[i] && (g_q[i] || asid_q[i] == s_asid) &&
                     ((ps_q[i] == PS_W'(PS_4M)) ?
                      (vppn_q[i][VPPN_W-1:PS_4M-PS_4K] == s_va[VA_W-1:PS_4M+1]) :
                      (vppn_q[i] == s_va[VA_W-1:PS_4K+1]));
        end
    end

    always_comb begin
        s_found = 1'b0;
        hit_idx = '0;
        for (int i = TLB_N - 1; i >= 0; i--) begin
            if (hit[i]) begin
                s_found = 1'b1;
                hit_idx = IDX_W'(i);        // lowest index wins
            end
        end
    end

    assign odd      = (ps_q[hit_idx] == PS_W'(PS_4M)) ? s_va[PS_4M] : s_va[PS_4K];
    assign half_sel = {hit_idx, odd};

    assign s_ps  = ps_q[hit_idx];
    assign s_ppn = ppn_q[half_sel];
    assign s_plv = plv_q[half_sel];
    assign s_mat = mat_q[half_sel];
    assign s_d   = d_q[half_sel];
    assign s_v   = v_q[half_sel];

endmodule

// ==== hdl/xlat_pipe.sv ====
module xlat_pipe (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              req_valid,
    input  logic [mmu_geom_pkg::VA_W-1:0]     req_va,
    input  mmu_csr_pkg::acc_e                 req_acc,
    input  logic [31:0]                       crmd,
    input  logic [31:0]                       dmw0,
    input  logic [31:0]                       dmw1,
    input  logic                              s_found,
    input  mmu_geom_pkg::ppn_t                s_ppn,
    input  logic [mmu_geom_pkg::PS_W-1:0]     s_ps,
    input  logic [1:0]                        s_plv,
    input  logic                              s_d,
    input  logic                              s_v,
    input  logic                              rsp_credit,
    output logic [mmu_geom_pkg::VA_W-1:0]     s_va,
    output logic                              req_credit,
    output logic                              rsp_valid,
    output logic                              rsp_fault,
    output mmu_geom_pkg::xlat_word_u          rsp_word
);
    import mmu_geom_pkg::*;
    import mmu_csr_pkg::*;

    logic             s1_vld;
    logic [VA_W-1:0]  s1_va;
    acc_e             s1_acc;
    logic             s1_found;
    ppn_t             s1_ppn;
    logic [PS_W-1:0]  s1_ps;
    logic [1:0]       s1_plv;
    logic             s1_d;
    logic             s1_v;

    logic [1:0]       cur_plv;
    logic             win0;
    logic             win1;
    logic             s2_fault;
    xlat_word_u       s2_word;

    xlat_word_u       q_word [XLAT_DEPTH];
    logic             q_fault [XLAT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_cnt;
    logic [CNT_W-1:0] rsp_cnt;              // response credits held
    logic             push;
    logic             pop;

    function automatic logic dmw_hit(input logic [31:0] dmw, input logic [2:0] vseg,
                                     input logic [1:0] plv);
        return (dmw[DMW_VSEG_LSB +: 3] == vseg) &&
               ((plv == 2'd0 && dmw[DMW_PLV0]) || (plv == 2'd3 && dmw[DMW_PLV3]));
    endfunction

    assign s_va = req_va;                   // tlb search runs in the request cycle

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            s1_va    <= req_va;
            s1_acc   <= req_acc;
            s1_found <= s_found;
            s1_ppn   <= s_ppn;
            s1_ps    <= s_ps;
            s1_plv   <= s_plv;
            s1_d     <= s_d;
            s1_v     <= s_v;
        end
    end

    assign cur_plv = crmd[CRMD_PLV_LSB +: 2];
    assign win0    = dmw_hit(dmw0, s1_va[31:29], cur_plv);
    assign win1    = dmw_hit(dmw1, s1_va[31:29], cur_plv);

    // stage 2, mode select then fault priority
    always_comb begin
        s2_fault = 1'b1;
        s2_word  = '0;
        if (crmd[CRMD_DA]) begin
            s2_fault   = 1'b0;
            s2_word.pa = s1_va;
        end else if (crmd[CRMD_PG] && win0) begin
            s2_fault   = 1'b0;
            s2_word.pa = {dmw0[DMW_PSEG_LSB +: 3], s1_va[28:0]};
        end else if (crmd[CRMD_PG] && win1) begin
            s2_fault   = 1'b0;
            s2_word.pa = {dmw1[DMW_PSEG_LSB +: 3], s1_va[28:0]};
        end else if (!s1_found) begin
            s2_word.fault.ecode = EC_TLBR;
        end else if (!s1_v) begin
            case (s1_acc)
                ACC_FETCH: s2_word.fault.ecode = EC_PIF;
                ACC_STORE: s2_word.fault.ecode = EC_PIS;
                default:   s2_word.fault.ecode = EC_PIL;
            endcase
        end else if (cur_plv > s1_plv) begin
            s2_word.fault.ecode = EC_PPI;
        end else if (s1_acc == ACC_STORE && !s1_d) begin
            s2_word.fault.ecode = EC_PME;
        end else begin
            s2_fault   = 1'b0;
            s2_word.pa = (s1_ps == PS_W'(PS_4M)) ?
                         {s1_ppn[PPN_W-1:PS_4M-PS_4K], s1_va[PS_4M-1:0]} :
                         {s1_ppn, s1_va[PS_4K-1:0]};
        end
    end

    assign push = s1_vld;
    assign pop  = (q_cnt != '0) && (rsp_cnt != '0);   // needs a result and a credit

    always_ff @(posedge aclk) begin
        if (push) begin
            q_word[wr_ptr]  <= s2_word;
            q_fault[wr_ptr] <= s2_fault;
        end
        if (pop) begin
            rsp_word  <= q_word[rd_ptr];
            rsp_fault <= q_fault[rd_ptr];
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            rsp_cnt   <= CNT_W'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_cnt     <= q_cnt + CNT_W'(push) - CNT_W'(pop);
            rsp_cnt   <= rsp_cnt + CNT_W'(rsp_credit) - CNT_W'(pop);
            rsp_valid <= pop;
        end
    end

    // a result leaving the queue frees one requester slot
    assign req_credit = rsp_valid;

endmodule

// ==== hdl/mmu_top.sv ====
module mmu_top (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              cfg_we,
    input  mmu_csr_pkg::cfg_sel_e             cfg_sel,
    input  logic [31:0]                       cfg_wdata,
    input  logic                              req_valid,
    input  logic [mmu_geom_pkg::VA_W-1:0]     req_va,
    input  mmu_csr_pkg::acc_e                 req_acc,
    output logic                              req_credit,
    output logic                              rsp_valid,
    output logic                              rsp_fault,
    output mmu_geom_pkg::xlat_word_u          rsp_word,
    input  logic                              rsp_credit
);
    import mmu_geom_pkg::*;

    logic [31:0]      crmd;
    logic [31:0]      dmw0;
    logic [31:0]      dmw1;
    asid_t            asid;

    // tlb write group
    logic             tlb_we;
    logic [IDX_W-1:0] tlb_idx;
    logic             w_e;
    logic [PS_W-1:0]  w_ps;
    vppn_t            w_vppn;
    asid_t            w_asid;
    logic             w_g;
    logic [31:0]      w_lo0;
    logic [31:0]      w_lo1;

    // tlb search port
    logic [VA_W-1:0]  s_va;
    logic             s_found;
    ppn_t             s_ppn;
    logic [PS_W-1:0]  s_ps;
    logic [1:0]       s_plv;
    logic             s_d;
    logic             s_v;

    mmu_csr_regs i_regs (.*);

    tlb_array i_tlb (
        .*,
        .s_asid (asid),
        .s_mat  ()                          // memory attribute not carried in response
    );

    xlat_pipe i_pipe (.*);

endmodule

// ==== sim/tb_mmu_asserts.sv ====
module tb_mmu_asserts (
    input logic                              aclk,
    input logic                              arst_n,
    input logic                              req_valid,
    input logic                              req_credit,
    input logic                              rsp_valid,
    input logic                              rsp_credit,
    input logic [mmu_geom_pkg::CNT_W-1:0]    q_cnt
);
    import mmu_geom_pkg::*;

    int   rsp_cred;                         // consumer credits held by the unit
    int   in_flight;                        // requests not yet credited back
    logic cred_d;                           // a returned credit counts from the next edge

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            cred_d    <= 1'b0;
            rsp_cred  <= RSP_CREDITS;
            in_flight <= 0;
        end else begin
            cred_d    <= rsp_credit;
            rsp_cred  <= rsp_cred + int'(cred_d) - int'(rsp_valid);
            in_flight <= in_flight + int'(req_valid) - int'(req_credit);
        end
    end

    rsp_has_credit: assert property (@(posedge aclk) disable iff (!arst_n)
        rsp_valid |-> rsp_cred > 0)
        else $error("response issued without a credit");

    queue_bounded: assert property (@(posedge aclk) disable iff (!arst_n)
        q_cnt <= CNT_W'(XLAT_DEPTH))
        else $error("result queue holds more than its depth");

    credit_for_request: assert property (@(posedge aclk) disable iff (!arst_n)
        req_credit |-> in_flight > 0)   // slot frees only for an accepted request
        else $error("req_credit without an outstanding request");

endmodule

bind xlat_pipe tb_mmu_asserts i_asserts (.*);

// ==== sim/tb_mmu.sv ====
module tb_mmu;
    import mmu_geom_pkg::*;
    import mmu_csr_pkg::*;

    logic        aclk;
    logic        arst_n;
    logic        cfg_we;
    cfg_sel_e    cfg_sel;
    logic [31:0] cfg_wdata;
    logic        req_valid;
    logic [31:0] req_va;
    acc_e        req_acc;
    logic        req_credit;
    logic        rsp_valid;
    logic        rsp_fault;
    xlat_word_u  rsp_word;
    logic        rsp_credit;

    // copy of the configuration for the reference model
    logic [31:0]      m_crmd = '0;
    logic [31:0]      m_dmw0 = '0;
    logic [31:0]      m_dmw1 = '0;
    asid_t            m_asid = '0;
    logic [31:0]      st_ehi = '0;
    logic [31:0]      st_lo0 = '0;
    logic [31:0]      st_lo1 = '0;
    logic [31:0]      st_idx = '0;
    logic [TLB_N-1:0] t_e = '0;
    logic [TLB_N-1:0] t_g = '0;
    logic [TLB_N-1:0] t_big = '0;
    vppn_t            t_vppn [TLB_N];
    asid_t            t_asid [TLB_N];
    logic [31:0]      t_lo0 [TLB_N];
    logic [31:0]      t_lo1 [TLB_N];

    logic [15:0]      lfsr = 16'd39342;
    logic [32:0]      exp_q [$];           // {fault, word} per request
    logic [32:0]      rsp_log [256];       // filled by the monitor only
    int               n_rsp = 0;
    int               rd_rsp = 0;
    int               n_req_credit = 0;
    int               sent = 0;
    int               checks = 0;
    int               errors = 0;
    int               timeouts = 0;

    mmu_top i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(negedge aclk) begin
        if (arst_n && rsp_valid) begin
            rsp_log[n_rsp] <= {rsp_fault, rsp_word};
            n_rsp          <= n_rsp + 1;
        end
        if (arst_n && req_credit) begin
            n_req_credit <= n_req_credit + 1;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic window(input logic [31:0] dmw, input logic [31:0] va,
                                    input logic [1:0] plv);
        return (dmw[31:29] == va[31:29]) && ((plv == 2'd0 && dmw[0]) || (plv == 2'd3 && dmw[3]));
    endfunction

    function automatic logic [32:0] model(input logic [31:0] va, input acc_e acc);
        logic [1:0]  plv;
        logic [31:0] lo;
        logic [5:0]  ec;
        logic        odd;
        int          hit;
        plv = m_crmd[1:0];
        hit = -1;
        if (m_crmd[3]) begin
            return {1'b0, va};
        end
        if (m_crmd[4] && window(m_dmw0, va, plv)) begin
            return {1'b0, m_dmw0[27:25], va[28:0]};
        end
        if (m_crmd[4] && window(m_dmw1, va, plv)) begin
            return {1'b0, m_dmw1[27:25], va[28:0]};
        end
        for (int i = TLB_N - 1; i >= 0; i--) begin
            if (t_e[i] && (t_g[i] || t_asid[i] == m_asid) &&
                (t_big[i] ? (t_vppn[i][18:9] == va[31:22]) : (t_vppn[i] == va[31:13]))) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            return {1'b1, EC_TLBR, 26'b0};
        end
        odd = t_big[hit] ? va[21] : va[12];
        lo  = odd ? t_lo1[hit] : t_lo0[hit];
        if (!lo[0]) begin
            ec = (acc == ACC_FETCH) ? EC_PIF : (acc == ACC_STORE) ? EC_PIS : EC_PIL;
            return {1'b1, ec, 26'b0};
        end
        if (plv > lo[3:2]) begin
            return {1'b1, EC_PPI, 26'b0};
        end
        if (acc == ACC_STORE && !lo[1]) begin
            return {1'b1, EC_PME, 26'b0};
        end
        if (t_big[hit]) begin
            return {1'b0, lo[27:17], va[20:0]};
        end
        return {1'b0, lo[27:8], va[11:0]};
    endfunction

    function automatic logic [31:0] elo(input logic [19:0] ppn, input logic [1:0] plv,
                                        input logic d, input logic v, input logic g);
        return {4'b0, ppn, 1'b0, g, 2'b00, plv, d, v};
    endfunction

    task automatic cfg_write(input cfg_sel_e sel, input logic [31:0] data);
        logic [3:0] idx;
        @(posedge aclk);
        cfg_we    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(posedge aclk);
        cfg_we    <= 1'b0;
        idx = st_idx[3:0];
        case (sel)
            SEL_CRMD:    m_crmd = data;
            SEL_DMW0:    m_dmw0 = data;
            SEL_DMW1:    m_dmw1 = data;
            SEL_ASID:    m_asid = data[9:0];
            SEL_TLBEHI:  st_ehi = data;
            SEL_TLBELO0: st_lo0 = data;
            SEL_TLBELO1: st_lo1 = data;
            SEL_TLBIDX:  st_idx = data;
            default: begin
                t_e[idx]    = ~st_idx[31];
                t_g[idx]    = st_lo0[6] & st_lo1[6];
                t_big[idx]  = (st_idx[29:24] == 6'd21);
                t_vppn[idx] = st_ehi[31:13];
                t_asid[idx] = m_asid;
                t_lo0[idx]  = st_lo0;
                t_lo1[idx]  = st_lo1;
            end
        endcase
    endtask

    task automatic tlb_write(input logic [3:0] idx, input logic big, input vppn_t vppn,
                             input logic [31:0] lo0, input logic [31:0] lo1);
        cfg_write(SEL_TLBEHI, {vppn, 13'b0});
        cfg_write(SEL_TLBELO0, lo0);
        cfg_write(SEL_TLBELO1, lo1);
        cfg_write(SEL_TLBIDX, {2'b00, big ? 6'd21 : 6'd12, 20'b0, idx});
        cfg_write(SEL_TLBWR, '0);
    endtask

    task automatic send(input logic [31:0] va, input acc_e acc);
        int t;
        t = 0;
        while (sent - n_req_credit >= XLAT_DEPTH && t < 40) begin
            @(posedge aclk);
            t++;
        end
        if (sent - n_req_credit >= XLAT_DEPTH) begin
            timeouts++;
            $display("timeout at %0t: no request credit came back", $time);
        end
        @(posedge aclk);
        req_valid <= 1'b1;
        req_va    <= va;
        req_acc   <= acc;
        sent++;
        exp_q.push_back(model(va, acc));
    endtask

    task automatic req_stop();
        @(posedge aclk);
        req_valid <= 1'b0;
    endtask

    task automatic give_credits(input int n);
        @(posedge aclk);
        rsp_credit <= 1'b1;
        repeat (n - 1) @(posedge aclk);
        @(posedge aclk);
        rsp_credit <= 1'b0;
    endtask

    task automatic wait_rsp(input int cnt);
        int t;
        t = 0;
        while (n_rsp - rd_rsp < cnt && t < 40) begin
            @(posedge aclk);
            t++;
        end
        if (n_rsp - rd_rsp < cnt) begin
            timeouts++;
            $display("timeout at %0t: waited for %0d responses, %0d arrived", $time, cnt,
                     n_rsp - rd_rsp);
        end
    endtask

    task automatic collect(input int n, input logic ret);
        logic [32:0] got;
        logic [32:0] exp;
        for (int k = 0; k < n; k++) begin
            wait_rsp(1);
            if (n_rsp == rd_rsp) begin
                return;
            end
            got = rsp_log[rd_rsp];
            rd_rsp++;
            exp = exp_q.pop_front();
            checks++;
            assert (got[32] == exp[32]) else begin
                errors++;
                $display("** Error at %0t: rsp_fault expected %b, got %b", $time, exp[32], got[32]);
            end
            assert (got[31:0] == exp[31:0]) else begin
                errors++;
                $display("** Error at %0t: rsp_word expected %h, got %h", $time, exp[31:0],
                         got[31:0]);
            end
            if (ret) begin
                give_credits(1);
            end
        end
    endtask

    task automatic check_xlat(input logic [31:0] va, input acc_e acc);
        send(va, acc);
        req_stop();
        collect(1, 1'b1);
    endtask

    task automatic direct_mode();
        logic [31:0] r;
        cfg_write(SEL_CRMD, 32'h0000_0008);     // da
        for (int i = 0; i < 6; i++) begin
            r = rand_word(32);
            check_xlat(r, acc_e'(i % 3));
        end
    endtask

    task automatic dmw_windows();
        logic [31:0] r;
        cfg_write(SEL_DMW0, 32'ha200_0001);     // vseg 5 to pseg 1, plv0 only
        cfg_write(SEL_DMW1, 32'h8c00_0008);     // vseg 4 to pseg 6, plv3 only
        for (int p = 0; p < 2; p++) begin
            cfg_write(SEL_CRMD, p == 0 ? 32'h0000_0010 : 32'h0000_0013);
            for (int i = 0; i < 2; i++) begin
                r = rand_word(29);
                check_xlat({3'b101, r[28:0]}, ACC_LOAD);
                check_xlat({3'b100, r[28:0]}, ACC_FETCH);   // empty tlb behind it
            end
        end
    endtask

    task automatic tlb_pages();
        logic [31:0] r;
        cfg_write(SEL_DMW0, '0);
        cfg_write(SEL_DMW1, '0);
        cfg_write(SEL_CRMD, 32'h0000_0010);
        cfg_write(SEL_ASID, 32'd5);
        tlb_write(4'd0, 1'b0, 19'h12340, elo(20'h0aaaa, 2'd0, 1, 1, 0),
                  elo(20'h0bbbb, 2'd0, 1, 1, 0));
        tlb_write(4'd1, 1'b1, 19'h2a000, elo(20'hc0000, 2'd0, 1, 1, 1),
                  elo(20'hd0200, 2'd0, 1, 1, 1));
        for (int a = 0; a < 2; a++) begin
            cfg_write(SEL_ASID, a == 0 ? 32'd5 : 32'd7);   // entry 0 misses under asid 7
            for (int i = 0; i < 4; i++) begin
                r = rand_word(21);
                check_xlat({19'h12340, i[0], r[11:0]}, ACC_LOAD);
                check_xlat({10'h150, i[0], r[20:0]}, ACC_STORE);
            end
        end
    endtask

    task automatic fault_codes();
        logic [31:0] r;
        r = rand_word(12);
        // even page invalid, odd page valid but clean
        tlb_write(4'd2, 1'b0, 19'h05550, elo(20'h11111, 2'd0, 0, 0, 1),
                  elo(20'h22222, 2'd0, 0, 1, 1));
        check_xlat({19'h7ffff, 1'b0, r[11:0]}, ACC_LOAD);
        for (int i = 0; i < 3; i++) begin
            check_xlat({19'h05550, 1'b0, r[11:0]}, acc_e'(i));
        end
        check_xlat({19'h05550, 1'b1, r[11:0]}, ACC_STORE);
        check_xlat({19'h05550, 1'b1, r[11:0]}, ACC_LOAD);
        cfg_write(SEL_CRMD, 32'h0000_0013);
        check_xlat({19'h05550, 1'b1, r[11:0]}, ACC_LOAD);
    endtask

    task automatic credit_order();
        int base;
        cfg_write(SEL_CRMD, 32'h0000_0008);
        base = n_req_credit;
        for (int i = 0; i < 4; i++) begin
            send(rand_word(32), ACC_LOAD);
        end
        req_stop();
        wait_rsp(RSP_CREDITS);
        repeat (8) @(posedge aclk);            // no response may pass the credit limit
        assert (n_rsp - rd_rsp == RSP_CREDITS) else begin
            errors++;
            $display("** Error at %0t: responses without credit expected %0d, got %0d", $time,
                     RSP_CREDITS, n_rsp - rd_rsp);
        end
        give_credits(2);
        collect(4, 1'b0);
        give_credits(2);
        assert (n_req_credit - base == 4) else begin
            errors++;
            $display("** Error at %0t: req_credit pulses expected 4, got %0d", $time,
                     n_req_credit - base);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        cfg_we     = 1'b0;
        cfg_sel    = SEL_CRMD;
        cfg_wdata  = '0;
        req_valid  = 1'b0;
        req_va     = '0;
        req_acc    = ACC_FETCH;
        rsp_credit = 1'b0;
        repeat (10) @(posedge aclk);
        arst_n <= 1'b1;
        @(posedge aclk);
        direct_mode();
        dmw_windows();
        tlb_pages();
        fault_codes();
        credit_order();
        repeat (5) @(posedge aclk);
        assert (n_rsp == rd_rsp) else begin
            errors++;
            $display("unexpected extra responses at the end of the run");
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/mmu_geom_pkg.sv
hdl/mmu_csr_pkg.sv
hdl/mmu_csr_regs.sv
hdl/tlb_array.sv
hdl/xlat_pipe.sv
hdl/mmu_top.sv
sim/tb_mmu_asserts.sv
sim/tb_mmu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mmu -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mmu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
